/* verilog/regblock_pkg.sv */
package regblock_pkg;

   localparam int DATA_W  = 8;
   localparam int ADDR_W  = 2;
   localparam int INSTR_W = 16;
   localparam int OPC_W   = 4;

   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [ADDR_W-1:0]  reg_addr_t;
   typedef logic [INSTR_W-1:0] instr_t;

   // Field positions inside the instruction word
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 12;
   localparam int DST_MSB  = 11;
   localparam int DST_LSB  = 10;
   localparam int SRCA_MSB = 9;
   localparam int SRCA_LSB = 8;
   localparam int IMM_MSB  = 7;
   localparam int IMM_LSB  = 0;
   // Source B shares the low bits of the immediate
   localparam int SRCB_MSB = 1;
   localparam int SRCB_LSB = 0;

   // Values 8 to 15 are not listed and decode as illegal
   typedef enum logic [OPC_W-1:0] {
      OP_NOP   = 4'd0,
      OP_LOADI = 4'd1,
      OP_MOV   = 4'd2,
      OP_ADD   = 4'd3,
      OP_SUB   = 4'd4,
      OP_AND   = 4'd5,
      OP_OR    = 4'd6,
      OP_XOR   = 4'd7
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_PASS_A,
      ALU_PASS_IMM,
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

endpackage

/* verilog/block_reg.sv */
`timescale 1ns/1ps

module block_reg import regblock_pkg::*; #(
   parameter int NUM_REGS = 4
) (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      wr_en,
   input  reg_addr_t wr_addr,
   input  data_t     wr_data,
   input  reg_addr_t rd_addr_a,
   input  reg_addr_t rd_addr_b,
   input  reg_addr_t obs_sel,
   output data_t     rd_data_a,
   output data_t     rd_data_b,
   output data_t     obs_data
);

   data_t regs [NUM_REGS];

   // Indices past NUM_REGS read as zero
   function automatic data_t read_reg(input reg_addr_t addr);
      data_t val;
      val = '0;
      for (int i = 0; i < NUM_REGS; i++) begin
         if (int'(addr) == i) begin
            val = regs[i];
         end
      end
      return val;
   endfunction

   // Write port, a write to an index that does not exist is dropped
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            if (int'(wr_addr) == i) begin
               regs[i] <= wr_data;
            end
         end
      end
   end

   always_comb begin
      rd_data_a = read_reg(rd_addr_a);
   end

   always_comb begin
      rd_data_b = read_reg(rd_addr_b);
   end

   // Observation port, sees a write right after the writing edge
   always_comb begin
      obs_data = read_reg(obs_sel);
   end

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import regblock_pkg::*; (
   input  alu_op_e alu_op,
   input  data_t   a,
   input  data_t   b,
   input  data_t   imm,
   output data_t   y
);

   data_t sum;
   data_t diff;

   // Both wrap modulo 256 by truncation to the data width
   assign sum  = a + b;
   assign diff = a - b;

   always_comb begin
      case (alu_op)
         ALU_PASS_A: begin
            y = a;
         end
         ALU_PASS_IMM: begin
            y = imm;
         end
         ALU_ADD: begin
            y = sum;
         end
         ALU_SUB: begin
            y = diff;
         end
         ALU_AND: begin
            y = a & b;
         end
         ALU_OR: begin
            y = a | b;
         end
         ALU_XOR: begin
            y = a ^ b;
         end
         default: begin
            y = '0;
         end
      endcase
   end

endmodule

/* verilog/op_sequencer.sv */
`timescale 1ns/1ps

module op_sequencer import regblock_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  instr_t    instr,
   input  logic      instr_valid,
   input  data_t     alu_out,
   output reg_addr_t rd_addr_a,
   output reg_addr_t rd_addr_b,
   output reg_addr_t wr_addr,
   output logic      wr_en,
   output alu_op_e   alu_op,
   output data_t     imm,
   output data_t     result,
   output logic      result_valid,
   output logic      error
);

   // Capture stage
   logic             cap_valid;
   logic [OPC_W-1:0] cap_opc;
   reg_addr_t        cap_dst;
   reg_addr_t        cap_srca;
   data_t            cap_imm;

   // Decode of the captured opcode
   logic op_legal;
   logic op_writes;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (instr_valid) begin
         cap_opc  <= instr[OPC_MSB:OPC_LSB];
         cap_dst  <= instr[DST_MSB:DST_LSB];
         cap_srca <= instr[SRCA_MSB:SRCA_LSB];
         cap_imm  <= instr[IMM_MSB:IMM_LSB];
      end
   end

   always_comb begin
      op_legal  = 1'b1;
      op_writes = 1'b1;
      alu_op    = ALU_PASS_A;
      case (opcode_e'(cap_opc))
         OP_NOP: begin
            op_writes = 1'b0;
         end
         OP_LOADI: begin
            alu_op = ALU_PASS_IMM;
         end
         OP_MOV: begin
            alu_op = ALU_PASS_A;
         end
         OP_ADD: begin
            alu_op = ALU_ADD;
         end
         OP_SUB: begin
            alu_op = ALU_SUB;
         end
         OP_AND: begin
            alu_op = ALU_AND;
         end
         OP_OR: begin
            alu_op = ALU_OR;
         end
         OP_XOR: begin
            alu_op = ALU_XOR;
         end
         default: begin
            op_legal  = 1'b0;
            op_writes = 1'b0;
         end
      endcase
   end

   assign rd_addr_a = cap_srca;
   assign rd_addr_b = cap_imm[SRCB_MSB:SRCB_LSB];
   assign wr_addr   = cap_dst;
   assign imm       = cap_imm;

   // The register file writes at the same edge that reports the result
   assign wr_en = cap_valid & op_writes;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result_valid <= 1'b0;
         error        <= 1'b0;
      end else begin
         result_valid <= cap_valid & op_legal;
         error        <= cap_valid & ~op_legal;
      end
   end

   // Result keeps its last value between reports
   always_ff @(posedge clk) begin
      if (cap_valid && op_legal) begin
         result <= alu_out;
      end
   end

endmodule

/* verilog/regblock_top.sv */
`timescale 1ns/1ps

module regblock_top import regblock_pkg::*; #(
   parameter int NUM_REGS = 4
) (
   input  logic      clk,
   input  logic      arst_n,
   input  instr_t    instr,
   input  logic      instr_valid,
   input  reg_addr_t obs_sel,
   output data_t     obs_data,
   output data_t     result,
   output logic      result_valid,
   output logic      error
);

   reg_addr_t rd_addr_a;
   reg_addr_t rd_addr_b;
   reg_addr_t wr_addr;
   logic      wr_en;
   alu_op_e   alu_op;
   data_t     imm;
   data_t     rd_data_a;
   data_t     rd_data_b;
   data_t     alu_out;

   op_sequencer u_seq (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr        (instr),
      .instr_valid  (instr_valid),
      .alu_out      (alu_out),
      .rd_addr_a    (rd_addr_a),
      .rd_addr_b    (rd_addr_b),
      .wr_addr      (wr_addr),
      .wr_en        (wr_en),
      .alu_op       (alu_op),
      .imm          (imm),
      .result       (result),
      .result_valid (result_valid),
      .error        (error)
   );

   block_reg #(
      .NUM_REGS (NUM_REGS)
   ) u_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (alu_out),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .obs_sel   (obs_sel),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .obs_data  (obs_data)
   );

   alu_unit u_alu (
      .alu_op (alu_op),
      .a      (rd_data_a),
      .b      (rd_data_b),
      .imm    (imm),
      .y      (alu_out)
   );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

   // Release lands just after a rising edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule

/* sim/regblock_chk.sv */
`timescale 1ns/1ps

module regblock_chk import regblock_pkg::*; (
   input logic   clk,
   input logic   arst_n,
   input instr_t instr,
   input logic   instr_valid,
   input logic   result_valid,
   input logic   error
);

   int fail_count = 0;

   logic illegal_in;

   // Opcodes above OP_XOR have no decode
   assign illegal_in = instr_valid && (instr[OPC_MSB:OPC_LSB] > 4'd7);

   a_latency: assert property (
      @(posedge clk) disable iff (!arst_n)
      instr_valid |-> ##2 (result_valid || error)
   ) else begin
      $error("No result or error two edges after an accepted instruction");
      fail_count++;
   end

   a_no_orphan: assert property (
      @(posedge clk) disable iff (!arst_n)
      (result_valid || error) |-> $past(instr_valid, 2)
   ) else begin
      $error("Result or error pulse without an instruction two edges earlier");
      fail_count++;
   end

   a_exclusive: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(result_valid && error)
   ) else begin
      $error("Result valid and error are high in the same cycle");
      fail_count++;
   end

   // Error must track the legality of the opcode two edges back
   a_error_opcode: assert property (
      @(posedge clk) disable iff (!arst_n)
      error == $past(illegal_in, 2)
   ) else begin
      $error("Error flag does not match the legality of the captured opcode");
      fail_count++;
   end

endmodule

/* sim/regblock_tb.sv */
`timescale 1ns/1ps

module regblock_tb import regblock_pkg::*; ();

   localparam int N_LOADI    = 4;
   localparam int N_DIRECTED = 4;
   localparam int N_PRELOAD  = 4;
   localparam int N_RAND_OPS = 36;
   localparam int N_CHAIN    = 16;
   localparam int N_ILLEGAL  = 8;
   localparam int N_NOP      = 2;
   localparam int N_STREAM   = 200;
   localparam int TOTAL_INSTR = N_LOADI + N_DIRECTED + N_PRELOAD + N_RAND_OPS + N_CHAIN
                                + N_ILLEGAL + N_NOP + N_STREAM;
   localparam int MAX_CYCLES = 2 * TOTAL_INSTR + 100;

   localparam int KIND_VAL = 0;
   localparam int KIND_ANY = 1;
   localparam int KIND_ERR = 2;

   logic      clk;
   logic      arst_n;
   instr_t    instr;
   logic      instr_valid;
   reg_addr_t obs_sel;
   data_t     obs_data;
   data_t     result;
   logic      result_valid;
   logic      error;

   data_t model [4];
   int    exp_kind [$];
   data_t exp_val [$];
   string exp_name [$];
   string test_name;
   int    value_errors;
   int    protocol_errors;
   int    assertion_errors;
   int    cycle_count;
   int    m_kind;
   data_t m_val;
   string m_name;

   tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) clk_gen (.clk(clk), .arst_n(arst_n));

   regblock_top #(.NUM_REGS(4)) dut0 (
      .clk (clk), .arst_n (arst_n), .instr (instr), .instr_valid (instr_valid),
      .obs_sel (obs_sel), .obs_data (obs_data), .result (result),
      .result_valid (result_valid), .error (error)
   );

   bind regblock_top regblock_chk chk0 (
      .clk (clk), .arst_n (arst_n), .instr (instr), .instr_valid (instr_valid),
      .result_valid (result_valid), .error (error)
   );

   function automatic instr_t make_instr(input logic [3:0] opc, input reg_addr_t dst,
                                         input reg_addr_t srca, input data_t imm_v);
      return {opc, dst, srca, imm_v};
   endfunction

   function automatic instr_t rand_instr(input logic [3:0] opc);
      return make_instr(opc, reg_addr_t'($urandom_range(3, 0)),
                        reg_addr_t'($urandom_range(3, 0)), data_t'($urandom_range(255, 0)));
   endfunction

   // Reference model, applied in issue order
   function automatic void predict(input instr_t w);
      logic [3:0] opc;
      reg_addr_t  dst;
      data_t      imm_v;
      data_t      a;
      data_t      b;
      data_t      y;
      opc   = w[OPC_MSB:OPC_LSB];
      dst   = w[DST_MSB:DST_LSB];
      imm_v = w[IMM_MSB:IMM_LSB];
      a     = model[w[SRCA_MSB:SRCA_LSB]];
      b     = model[imm_v[SRCB_MSB:SRCB_LSB]];
      y     = '0;
      case (opc)
         OP_LOADI: y = imm_v;
         OP_MOV:   y = a;
         OP_ADD:   y = a + b;
         OP_SUB:   y = a - b;
         OP_AND:   y = a & b;
         OP_OR:    y = a | b;
         OP_XOR:   y = a ^ b;
         default:  y = '0;
      endcase
      if (opc == OP_NOP) begin
         exp_kind.push_back(KIND_ANY);
      end else if (opc > 4'd7) begin
         exp_kind.push_back(KIND_ERR);
      end else begin
         model[dst] = y;
         exp_kind.push_back(KIND_VAL);
      end
      exp_val.push_back(y);
      exp_name.push_back(test_name);
   endfunction

   task automatic issue(input instr_t w);
      @(posedge clk);
      #1;
      instr       = w;
      instr_valid = 1'b1;
      predict(w);
   endtask

   task automatic idle();
      @(posedge clk);
      #1;
      instr       = '0;
      instr_valid = 1'b0;
   endtask

   task automatic drain();
      idle();
      while (exp_kind.size() > 0) begin
         @(negedge clk);
      end
   endtask

   task automatic check_regs(input string name);
      for (int r = 0; r < 4; r++) begin
         @(posedge clk);
         #1;
         obs_sel = reg_addr_t'(r);
         @(negedge clk);
         assert (obs_data == model[r]) else begin
            value_errors++;
            $display("** Error [%s] r%0d: expected 0x%02h, actual 0x%02h",
                     name, r, model[r], obs_data);
         end
      end
   endtask

   // Responses come back in issue order, checked mid-cycle
   always @(negedge clk) begin
      if (arst_n && (result_valid || error)) begin
         if (exp_kind.size() == 0) begin
            protocol_errors++;
            $display("Output pulse seen with no instruction outstanding");
         end else begin
            m_kind = exp_kind.pop_front();
            m_val  = exp_val.pop_front();
            m_name = exp_name.pop_front();
            assert (error == (m_kind == KIND_ERR)) else begin
               value_errors++;
               $display("** Error [%s] error flag: expected %0d, actual %0d",
                        m_name, m_kind == KIND_ERR, error);
            end
            if (m_kind == KIND_VAL) begin
               assert (result == m_val) else begin
                  value_errors++;
                  $display("** Error [%s] result: expected 0x%02h, actual 0x%02h",
                           m_name, m_val, result);
               end
            end
         end
      end
   end

   initial begin
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run stopped by timeout after %0d cycles", cycle_count);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      reg_addr_t prev_dst;
      instr_t    w;
      void'($urandom(27));
      instr            = '0;
      instr_valid      = 1'b0;
      obs_sel          = '0;
      value_errors     = 0;
      protocol_errors  = 0;
      assertion_errors = 0;
      cycle_count      = 0;
      for (int r = 0; r < 4; r++) begin
         model[r] = '0;
      end
      wait (arst_n === 1'b1);

      test_name = "reset";
      repeat (3) idle();
      check_regs(test_name);

      test_name = "loadi";
      for (int r = 0; r < N_LOADI; r++) begin
         issue(make_instr(OP_LOADI, reg_addr_t'(r), 2'd0, data_t'($urandom_range(255, 0))));
      end
      drain();
      check_regs(test_name);

      // Directed wraparound on add and subtract, then random operands
      test_name = "alu_ops";
      issue(make_instr(OP_LOADI, 2'd0, 2'd0, 8'hf0));
      issue(make_instr(OP_LOADI, 2'd1, 2'd0, 8'h20));
      issue(make_instr(OP_ADD, 2'd2, 2'd0, 8'h01));
      issue(make_instr(OP_SUB, 2'd3, 2'd1, 8'h00));
      for (int r = 0; r < N_PRELOAD; r++) begin
         issue(make_instr(OP_LOADI, reg_addr_t'(r), 2'd0, data_t'($urandom_range(255, 0))));
      end
      for (int i = 0; i < N_RAND_OPS; i++) begin
         issue(rand_instr(4'($urandom_range(7, 2))));
      end
      drain();
      check_regs(test_name);

      test_name = "dependent";
      prev_dst  = 2'd0;
      for (int i = 0; i < N_CHAIN; i++) begin
         w = rand_instr(4'($urandom_range(7, 2)));
         w[SRCA_MSB:SRCA_LSB] = prev_dst;
         if (i % 2 == 1) begin
            w[SRCB_MSB:SRCB_LSB] = prev_dst;
         end
         prev_dst = w[DST_MSB:DST_LSB];
         issue(w);
      end
      drain();
      check_regs(test_name);

      test_name = "illegal";
      for (int i = 0; i < N_ILLEGAL; i++) begin
         issue(rand_instr(4'(8 + i)));
      end
      drain();
      check_regs(test_name);

      test_name = "nop";
      for (int i = 0; i < N_NOP; i++) begin
         issue(rand_instr(OP_NOP));
      end
      drain();
      check_regs(test_name);

      test_name = "stream";
      for (int i = 0; i < N_STREAM; i++) begin
         if ($urandom_range(3, 0) == 0) begin
            idle();
         end
         issue(rand_instr(4'($urandom_range(15, 0))));
      end
      drain();
      check_regs(test_name);

      assertion_errors = dut0.chk0.fail_count;
      $display("Errors: value %0d, protocol %0d, assertion %0d",
               value_errors, protocol_errors, assertion_errors);
      if (value_errors + protocol_errors + assertion_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* src.f */
verilog/regblock_pkg.sv
verilog/block_reg.sv
verilog/alu_unit.sv
verilog/op_sequencer.sv
verilog/regblock_top.sv
sim/tb_clock_gen.sv
sim/regblock_chk.sv
sim/regblock_tb.sv

/* Bender.yml */
package:
  name: regblock

sources:
  # RTL in compile order
  - files:
      - verilog/regblock_pkg.sv
      - verilog/block_reg.sv
      - verilog/alu_unit.sv
      - verilog/op_sequencer.sv
      - verilog/regblock_top.sv

  # Testbench
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/regblock_chk.sv
      - sim/regblock_tb.sv
